// ==== design/issue_config.svh ====
`ifndef ISSUE_CONFIG_SVH
`define ISSUE_CONFIG_SVH

// instructions per dispatched block
`define ISSUE_SLOTS 8

// entries in each unit queue
`define QUEUE_DEPTH 8

// alu, lsu, csr, mul, div
`define NUM_UNITS   5

// instruction field widths
`define PAYLOAD_W   24
`define SLOT_IDX_W  4

`endif

// ==== design/issuePkg.sv ====
`include "issue_config.svh"

package issuePkg;

    // instruction class as decoded upstream
    typedef enum logic [2:0] {
        OP_ALU    = 3'd0,
        OP_LSU    = 3'd1,
        OP_MULDIV = 3'd2,
        OP_CSR    = 3'd3,
        OP_BJP    = 3'd4
    } opcode_t;

    // execution unit, also the queue index
    typedef enum logic [2:0] {
        UNIT_ALU = 3'd0,
        UNIT_LSU = 3'd1,
        UNIT_CSR = 3'd2,
        UNIT_MUL = 3'd3,
        UNIT_DIV = 3'd4
    } unit_t;

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_SCAN = 1'b1
    } scan_state_t;

    typedef struct packed {
        opcode_t               opcode;
        logic                  isDiv;
        logic [3:0]            tag;
        logic [`PAYLOAD_W-1:0] payload;
    } instr_t;

    // slot 0 is the oldest instruction of the block
    typedef struct packed {
        instr_t [`ISSUE_SLOTS-1:0] slots;
        logic [`SLOT_IDX_W-1:0]    cut;
    } block_t;

    typedef struct packed {
        logic   valid;
        unit_t  unit;
        instr_t instr;
    } issue_t;

endpackage

// ==== design/unitQueue.sv ====
`timescale 1ns/100ps
`include "issue_config.svh"

module unitQueue #(
    parameter int DEPTH = `QUEUE_DEPTH
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic             i_push,
    input  issuePkg::instr_t i_pushInstr,
    input  logic             i_pop,
    output issuePkg::instr_t o_head,
    output logic             o_empty,
    output logic             o_full
);

    import issuePkg::*;

    localparam int ADDR_W = $clog2(DEPTH);

    instr_t            mem [DEPTH];
    logic [ADDR_W-1:0] wrPtr;
    logic [ADDR_W-1:0] rdPtr;
    logic [ADDR_W:0]   count;
    logic              doPush;
    logic              doPop;

    assign o_empty = (count == '0);
    assign o_full  = (count == (ADDR_W + 1)'(DEPTH));
    assign o_head  = mem[rdPtr];

    assign doPush = i_push && !o_full;
    assign doPop  = i_pop && !o_empty;

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= i_pushInstr;
        end
    end

    // pointers wrap on their own for power of two depths
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== design/issueBlockScan.sv ====
`timescale 1ns/100ps
`include "issue_config.svh"

module issueBlockScan (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  i_blockValid,
    input  issuePkg::block_t      i_block,
    input  logic [`NUM_UNITS-1:0] i_queueFull,
    output logic                  o_blockFree,
    output logic [`NUM_UNITS-1:0] o_pushValid,
    output issuePkg::instr_t      o_pushInstr
);

    import issuePkg::*;

    localparam int SEL_W = $clog2(`ISSUE_SLOTS);

    scan_state_t            state;
    block_t                 blockReg;
    logic [`SLOT_IDX_W-1:0] slotIdx;
    instr_t                 curInstr;
    unit_t                  curUnit;
    logic                   curKeep;
    logic                   stall;
    logic                   lastSlot;

    // sorting rule, unknown opcodes fall back to alu
    function automatic unit_t classify(input instr_t instr);
        unit_t u;
        case (instr.opcode)
            OP_LSU:    u = UNIT_LSU;
            OP_CSR:    u = UNIT_CSR;
            OP_MULDIV: u = instr.isDiv ? UNIT_DIV : UNIT_MUL;
            default:   u = UNIT_ALU;
        endcase
        return u;
    endfunction

    assign curInstr = blockReg.slots[slotIdx[SEL_W-1:0]];
    assign curUnit  = classify(curInstr);

    // slots past the cut and branches are consumed without a push
    assign curKeep  = (slotIdx < blockReg.cut) && (curInstr.opcode != OP_BJP);
    assign stall    = curKeep && i_queueFull[curUnit];
    assign lastSlot = (int'(slotIdx) == `ISSUE_SLOTS - 1);

    assign o_blockFree = (state == ST_IDLE);
    assign o_pushInstr = curInstr;

    always_comb begin
        o_pushValid = '0;
        if (state == ST_SCAN && curKeep && !i_queueFull[curUnit]) begin
            o_pushValid[curUnit] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state   <= ST_IDLE;
            slotIdx <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_blockValid) begin
                        state   <= ST_SCAN;
                        slotIdx <= '0;
                    end
                end
                ST_SCAN: begin
                    // hold the slot while its queue is full
                    if (!stall) begin
                        slotIdx <= slotIdx + 1'b1;
                        if (lastSlot) begin
                            state <= ST_IDLE;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // block only captured when free, strobes while busy are dropped
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && i_blockValid) begin
            blockReg <= i_block;
        end
    end

endmodule

// ==== design/issueArbiter.sv ====
`timescale 1ns/100ps
`include "issue_config.svh"

module issueArbiter (
    input  logic                                    clk,
    input  logic                                    rstn,
    input  logic [`NUM_UNITS-1:0]                   i_queueEmpty,
    input  issuePkg::instr_t [`NUM_UNITS-1:0]       i_queueHead,
    input  logic [`NUM_UNITS-1:0]                   i_unitReady,
    output logic [`NUM_UNITS-1:0]                   o_pop,
    output issuePkg::issue_t                        o_issue
);

    import issuePkg::*;

    logic [`NUM_UNITS-1:0] request;
    unit_t                 rrPtr;
    unit_t                 grantIdx;
    logic                  anyGrant;
    logic                  issueValid;
    unit_t                 issueUnit;
    instr_t                issueInstr;

    // a stalled unit never competes
    assign request = ~i_queueEmpty & i_unitReady;

    // first request at or after the pointer wins
    always_comb begin
        int cand;
        grantIdx = rrPtr;
        anyGrant = 1'b0;
        o_pop    = '0;
        for (int k = 0; k < `NUM_UNITS; k++) begin
            cand = int'(rrPtr) + k;
            if (cand >= `NUM_UNITS) begin
                cand = cand - `NUM_UNITS;
            end
            if (!anyGrant && request[cand]) begin
                anyGrant    = 1'b1;
                grantIdx    = unit_t'(cand[2:0]);
                o_pop[cand] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rrPtr      <= UNIT_ALU;
            issueValid <= 1'b0;
        end else begin
            issueValid <= anyGrant;
            if (anyGrant) begin
                if (int'(grantIdx) == `NUM_UNITS - 1) begin
                    rrPtr <= UNIT_ALU;
                end else begin
                    rrPtr <= unit_t'(grantIdx + 3'd1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (anyGrant) begin
            issueUnit  <= grantIdx;
            issueInstr <= i_queueHead[grantIdx];
        end
    end

    assign o_issue = '{valid: issueValid, unit: issueUnit, instr: issueInstr};

endmodule

// ==== design/issueTop.sv ====
`timescale 1ns/100ps
`include "issue_config.svh"

module issueTop (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  i_blockValid,
    input  issuePkg::block_t      i_block,
    input  logic [`NUM_UNITS-1:0] i_unitReady,
    output logic                  o_blockFree,
    output issuePkg::issue_t      o_issue
);

    import issuePkg::*;

    logic [`NUM_UNITS-1:0]   pushValid;
    instr_t                  pushInstr;
    logic [`NUM_UNITS-1:0]   queueFull;
    logic [`NUM_UNITS-1:0]   queueEmpty;
    logic [`NUM_UNITS-1:0]   pop;
    instr_t [`NUM_UNITS-1:0] queueHead;

    issueBlockScan issueBlockScan_inst (
        .clk          (clk),
        .rstn         (rstn),
        .i_blockValid (i_blockValid),
        .i_block      (i_block),
        .i_queueFull  (queueFull),
        .o_blockFree  (o_blockFree),
        .o_pushValid  (pushValid),
        .o_pushInstr  (pushInstr)
    );

    // one queue per unit, indexed by unit_t
    for (genvar u = 0; u < `NUM_UNITS; u++) begin : g_queue
        unitQueue #(
            .DEPTH (`QUEUE_DEPTH)
        ) unitQueue_inst (
            .clk         (clk),
            .rstn        (rstn),
            .i_push      (pushValid[u]),
            .i_pushInstr (pushInstr),
            .i_pop       (pop[u]),
            .o_head      (queueHead[u]),
            .o_empty     (queueEmpty[u]),
            .o_full      (queueFull[u])
        );
    end

    issueArbiter issueArbiter_inst (
        .clk          (clk),
        .rstn         (rstn),
        .i_queueEmpty (queueEmpty),
        .i_queueHead  (queueHead),
        .i_unitReady  (i_unitReady),
        .o_pop        (pop),
        .o_issue      (o_issue)
    );

endmodule

// ==== dv/issueTb.sv ====
`timescale 1ns/100ps
`include "issue_config.svh"

module issueTb;

    import issuePkg::*;

    localparam int NUM_ROWS   = 6;
    localparam int WAIT_LIMIT = 300;

    // ops and divMask hold slot 7 leftmost
    typedef struct packed {
        logic [`ISSUE_SLOTS-1:0][2:0] ops;
        logic [`ISSUE_SLOTS-1:0]      divMask;
        logic [`SLOT_IDX_W-1:0]       cut;
        logic [`NUM_UNITS-1:0]        ready;
        logic                         drainFirst;
        logic                         extraStrobe;
    } stimRow_t;

    logic                  clk;
    logic                  rstn;
    logic                  i_blockValid;
    block_t                i_block;
    logic [`NUM_UNITS-1:0] i_unitReady;
    logic                  o_blockFree;
    issue_t                o_issue;

    stimRow_t              stimTable [NUM_ROWS];
    instr_t                expQ [`NUM_UNITS][$];
    logic [`NUM_UNITS-1:0] prevReady;
    logic                  fairCheck;
    int                    gap [`NUM_UNITS];
    integer                seed;

    issueTop issueTop_inst (
        .clk          (clk),
        .rstn         (rstn),
        .i_blockValid (i_blockValid),
        .i_block      (i_block),
        .i_unitReady  (i_unitReady),
        .o_blockFree  (o_blockFree),
        .o_issue      (o_issue)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stopWithError(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkValue(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
        if (actual !== expected) begin
            stopWithError($sformatf("ERR %0t %s actual=0x%0h expected=0x%0h",
                                    $time, name, actual, expected));
        end
    endtask

    // target unit straight from the sorting rule
    function automatic int expectedUnit(input instr_t instr);
        int u;
        u = int'(UNIT_ALU);
        if (instr.opcode == OP_LSU) begin
            u = int'(UNIT_LSU);
        end else if (instr.opcode == OP_CSR) begin
            u = int'(UNIT_CSR);
        end else if (instr.opcode == OP_MULDIV) begin
            u = instr.isDiv ? int'(UNIT_DIV) : int'(UNIT_MUL);
        end
        return u;
    endfunction

    function automatic bit modelEmpty();
        bit empty;
        empty = 1'b1;
        for (int u = 0; u < `NUM_UNITS; u++) begin
            if (expQ[u].size() != 0) begin
                empty = 1'b0;
            end
        end
        return empty;
    endfunction

    task automatic pushExpected(input block_t blk);
        instr_t instr;
        for (int i = 0; i < `ISSUE_SLOTS; i++) begin
            instr = blk.slots[i];
            if (i < int'(blk.cut) && instr.opcode != OP_BJP) begin
                expQ[expectedUnit(instr)].push_back(instr);
            end
        end
    endtask

    task automatic makeBlock(input stimRow_t row, output block_t blk);
        for (int i = 0; i < `ISSUE_SLOTS; i++) begin
            blk.slots[i].opcode  = opcode_t'(row.ops[i]);
            blk.slots[i].isDiv   = row.divMask[i];
            blk.slots[i].tag     = 4'($random(seed));
            blk.slots[i].payload = `PAYLOAD_W'($random(seed));
        end
        blk.cut = row.cut;
    endtask

    task automatic waitBlockFree();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!o_blockFree) begin
            if (cycles >= WAIT_LIMIT) begin
                stopWithError("timeout while waiting for o_blockFree to rise");
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic waitDrained();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!modelEmpty()) begin
            if (cycles >= WAIT_LIMIT) begin
                stopWithError("timeout with expected instructions that were never issued");
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic sendBlock(input block_t blk, input logic extra);
        stimRow_t junkRow;
        block_t   junk;
        @(posedge clk);
        i_blockValid <= 1'b1;
        i_block      <= blk;
        pushExpected(blk);
        @(posedge clk);
        if (extra) begin
            // scanner is busy so this block must vanish
            junkRow = '{ops: '0, divMask: '0, cut: 4'd8, ready: '1,
                        drainFirst: 1'b0, extraStrobe: 1'b0};
            makeBlock(junkRow, junk);
            i_block <= junk;
            @(negedge clk);
            checkValue("o_blockFree", o_blockFree, 1'b0);
            @(posedge clk);
        end
        i_blockValid <= 1'b0;
    endtask

    // each waiting unit must be served within NUM_UNITS issues
    task automatic updateGaps(input int winner);
        for (int u = 0; u < `NUM_UNITS; u++) begin
            if (u == winner || expQ[u].size() == 0) begin
                gap[u] = 0;
            end else begin
                gap[u]++;
                if (gap[u] >= `NUM_UNITS) begin
                    stopWithError($sformatf("unit %0d was passed over %0d times in a row",
                                            u, gap[u]));
                end
            end
        end
    endtask

    task automatic fillTable();
        // mixed opcodes with unknown opcode 6 landing on alu
        stimTable[0] = '{ops: {3'd6, OP_ALU, OP_MULDIV, OP_BJP,
                               OP_CSR, OP_MULDIV, OP_LSU, OP_ALU},
                         divMask: 8'b0110_0000, cut: 4'd8, ready: 5'b11111,
                         drainFirst: 1'b1, extraStrobe: 1'b0};
        // cut at 5 with branches inside the window
        stimTable[1] = '{ops: {OP_ALU, OP_LSU, OP_CSR, OP_MULDIV,
                               OP_BJP, OP_ALU, OP_BJP, OP_LSU},
                         divMask: 8'b0001_0000, cut: 4'd5, ready: 5'b11111,
                         drainFirst: 1'b1, extraStrobe: 1'b0};
        // lsu held off so its queue fills exactly
        stimTable[2] = '{ops: {8{OP_LSU}},
                         divMask: 8'b0000_0000, cut: 4'd8, ready: 5'b11101,
                         drainFirst: 1'b1, extraStrobe: 1'b0};
        // back to back block that stalls on slot 0
        stimTable[3] = '{ops: {OP_LSU, OP_MULDIV, OP_MULDIV, OP_LSU,
                               OP_CSR, OP_LSU, OP_ALU, OP_LSU},
                         divMask: 8'b0100_0000, cut: 4'd8, ready: 5'b11101,
                         drainFirst: 1'b0, extraStrobe: 1'b0};
        // lsu released plus a strobe while busy
        stimTable[4] = '{ops: {OP_CSR, OP_ALU, OP_BJP, OP_LSU,
                               OP_MULDIV, OP_MULDIV, OP_ALU, OP_CSR},
                         divMask: 8'b0000_0100, cut: 4'd7, ready: 5'b11111,
                         drainFirst: 1'b0, extraStrobe: 1'b1};
        // load every queue with all units stalled
        stimTable[5] = '{ops: {OP_MULDIV, OP_LSU, OP_ALU, OP_MULDIV,
                               OP_MULDIV, OP_CSR, OP_LSU, OP_ALU},
                         divMask: 8'b1001_0000, cut: 4'd8, ready: 5'b00000,
                         drainFirst: 1'b1, extraStrobe: 1'b0};
    endtask

    always @(negedge clk) begin : monitor
        int     u;
        instr_t want;
        if (rstn) begin
            if (o_issue.valid) begin
                u = int'(o_issue.unit);
                if (u >= `NUM_UNITS) begin
                    stopWithError("issue names a unit that does not exist");
                end else if (!prevReady[u]) begin
                    stopWithError($sformatf("unit %0d issued while its ready was low", u));
                end else if (expQ[u].size() == 0) begin
                    stopWithError($sformatf("unexpected issue to unit %0d", u));
                end else begin
                    want = expQ[u].pop_front();
                    checkValue("o_issue.instr", o_issue.instr, want);
                    if (fairCheck) begin
                        updateGaps(u);
                    end
                end
            end
            prevReady = i_unitReady;
        end
    end

    initial begin
        stimRow_t row;
        block_t   blk;
        seed         = 83;
        fairCheck    = 1'b0;
        prevReady    = '0;
        rstn         = 1'b0;
        i_blockValid = 1'b0;
        i_block      = '0;
        i_unitReady  = '1;
        for (int u = 0; u < `NUM_UNITS; u++) begin
            gap[u] = 0;
        end
        fillTable();
        repeat (8) @(posedge clk);
        rstn <= 1'b1;

        // idle after reset
        repeat (10) begin
            @(negedge clk);
            checkValue("o_blockFree", o_blockFree, 1'b1);
            checkValue("o_issue.valid", o_issue.valid, 1'b0);
        end

        for (int r = 0; r < NUM_ROWS; r++) begin
            row = stimTable[r];
            if (row.drainFirst) begin
                waitDrained();
            end
            @(posedge clk);
            i_unitReady <= row.ready;
            waitBlockFree();
            makeBlock(row, blk);
            sendBlock(blk, row.extraStrobe);
        end

        // open all units together on loaded queues
        waitBlockFree();
        @(posedge clk);
        fairCheck = 1'b1;
        i_unitReady <= '1;
        waitDrained();
        repeat (20) @(negedge clk);

        $display("Everything OK");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+design
design/issuePkg.sv
design/unitQueue.sv
design/issueBlockScan.sv
design/issueArbiter.sv
design/issueTop.sv
dv/issueTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the issue stage testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f project.f \
    --top-module issueTb \
    -o issueSim

out=$(./obj_dir/issueSim 2>&1) || true
printf '%s\n' "$out"

# pass only when the testbench reported success
if printf '%s\n' "$out" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1
